// File: decode_stage.f
design/decode_pkg.sv
design/inst_latch.sv
design/inst_decoder.sv
design/writeback_track.sv
design/hazard_resolve.sv
design/decode_stage.sv
bench/decode_stage_props.sv
bench/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
    --top-module decode_stage_tb -f decode_stage.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdecode_stage_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: bench/decode_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb
  import decode_pkg::*;
;

  localparam int DATA_WIDTH  = 32;
  localparam int CLK_PERIOD  = 100;
  localparam int NUM_RANDOM  = 240;
  localparam int READY_LIMIT = 20;
  // a stalled word can cost two extra cycles
  localparam int TEST_CYCLES = 16 + 3 * NUM_RANDOM + 100;

  typedef struct packed {
    logic [3:0]            rd;
    logic [3:0]            rn;
    logic [DATA_WIDTH-1:0] lit;
    logic [1:0]            op1;
    logic [1:0]            op2;
    logic [3:0]            opc;
    logic [3:0]            flags;
    logic                  br;
    logic                  cbr;
    logic                  rel;
    logic [2:0]            code;
    logic                  mrd;
    logic                  mwr;
    logic                  rwr;
    logic [1:0]            wb;
    logic [3:0]            wa;
    logic                  bad;
  } dec_t;

  logic                      clk;
  logic                      rst_i;
  logic                      flush_i;
  logic [INST_WIDTH-1:0]     instruction_i;
  logic                      inst_valid_i;
  logic [DATA_WIDTH-1:0]     inst_addr_i;
  logic                      fetch_ready_i;
  logic                      decode_ready_o;
  logic                      control_valid_o;
  logic [REG_ADDR_WIDTH-1:0] rd_addr_o;
  logic [REG_ADDR_WIDTH-1:0] rn_addr_o;
  logic [DATA_WIDTH-1:0]     literal_o;
  op_src_t                   op1_sel_o;
  op_src_t                   op2_sel_o;
  alu_op_t                   alu_opcode_o;
  logic [3:0]                store_flags_o;
  logic                      is_branch_o;
  logic                      is_cond_branch_o;
  logic                      branch_rel_abs_o;
  logic [2:0]                branch_code_o;
  logic [DATA_WIDTH-1:0]     branch_base_addr_o;
  logic                      mem_read_o;
  logic                      mem_write_o;
  logic                      reg_write_o;
  wb_src_t                   wb_src_o;
  logic [REG_ADDR_WIDTH-1:0] reg_write_addr_o;
  fwd_t                      rd_fwd_o;
  fwd_t                      rn_fwd_o;

  int                    errors = 0;
  logic [15:0]           lfsr;
  logic [DATA_WIDTH-1:0] next_addr;

  // model of the latch and of the write tracker
  logic [INST_WIDTH-1:0] m_inst;
  logic [DATA_WIDTH-1:0] m_addr;
  logic                  m_valid;
  logic                  m_w [3];
  logic [3:0]            m_a [3];
  logic                  m_l [3];
  dec_t                  exp;
  dec_t                  got;
  fwd_t                  e_rd_fwd;
  fwd_t                  e_rn_fwd;
  logic                  e_stall;

  decode_stage #(.DATA_WIDTH(DATA_WIDTH)) uut (.*);

  bind decode_stage decode_stage_props u_props (
    .clk(clk), .rst_i(rst_i), .flush_i(flush_i), .fetch_ready_i(fetch_ready_i),
    .stall_i(stall), .inst_i(inst_r), .valid_i(valid_r),
    .decode_ready_i(decode_ready_o), .control_valid_i(control_valid_o),
    .reg_write_i(reg_write_o), .mem_read_i(mem_read_o), .mem_write_i(mem_write_o),
    .is_branch_i(is_branch_o), .rd_fwd_i(rd_fwd_o), .rn_fwd_i(rn_fwd_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] random_word();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++)
      w = {w[14:0], lfsr_bit()};
    return w;
  endfunction

  function automatic dec_t ref_decode(input logic [15:0] w, input logic en);
    dec_t d;
    d = '0;
    if (!en)
      return d;
    case (w[15:13])
      3'b000:
      begin
        if (!w[12])
          d.bad = 1'b1;
        else
        begin
          d.rd  = w[7:4];
          d.op2 = SRC_RN;
          d.opc = w[11] ? OP_ZEX : OP_SEX;
          d.rwr = 1'b1;
          d.wa  = w[7:4];
        end
      end
      3'b001:
      begin
        d.rn   = w[3:0];
        d.lit  = DATA_WIDTH'($signed(w[7:0]));
        d.op2  = w[12] ? SRC_RN : SRC_LIT;
        d.opc  = OP_MOV;
        d.br   = 1'b1;
        d.cbr  = 1'b1;
        d.code = w[10:8];
        d.rel  = w[11];
        d.rwr  = w[11];
        d.wb   = WB_BRANCH;
        d.wa   = REG_LINK;
      end
      3'b010:
      begin
        d.rn  = w[3:0];
        d.lit = DATA_WIDTH'(w[7:0]);
        d.op1 = SRC_LIT;
        d.op2 = w[12] ? SRC_LIT : SRC_RN;
        d.opc = OP_MOV;
        d.rwr = 1'b1;
        d.wa  = w[11:8];
      end
      3'b011:
      begin
        d.rd  = w[11:8];
        d.rn  = w[7:4];
        d.lit = DATA_WIDTH'(w[3:0]);
        d.op1 = SRC_RN;
        d.op2 = SRC_LIT;
        d.opc = OP_ADD;
        d.mrd = !w[12];
        d.mwr = w[12];
        d.rwr = !w[12];
        d.wb  = WB_MEM;
        d.wa  = w[11:8];
      end
      3'b100, 3'b101:
      begin
        // alu and shift differ in rd, literal and opcode
        d.rd    = w[13] ? w[11:8] : w[7:4];
        d.rn    = w[3:0];
        d.lit   = w[13] ? DATA_WIDTH'(w[4:0]) : DATA_WIDTH'(w[3:0]);
        d.op2   = w[12] ? SRC_RN : SRC_LIT;
        d.opc   = w[13] ? 4'd12 + 4'(w[7:6]) : w[11:8];
        d.flags = 4'hf;
        d.rwr   = 1'b1;
        d.wa    = d.rd;
      end
      3'b110:
        d.bad = 1'b1;
      default:
      begin
        d.rn  = w[3:0];
        d.op2 = SRC_LIT;
        if (!w[12])
        begin
          d.rd  = REG_STACK;
          d.lit = DATA_WIDTH'(PUSH_POP_STEP);
          d.opc = w[11] ? OP_ADD : OP_SUB;
          d.mrd = w[11];
          d.mwr = !w[11];
          d.rwr = w[11];
          d.wb  = WB_MEM;
          d.wa  = w[3:0];
        end
        else
        begin
          d.lit = DATA_WIDTH'($signed(w[9:0]));
          d.op1 = SRC_LIT;
          d.op2 = w[11] ? SRC_RN : SRC_LIT;
          d.br  = 1'b1;
          d.rel = w[11];
          d.rwr = w[10];
          d.wb  = WB_BRANCH;
          d.wa  = REG_LINK;
        end
      end
    endcase
    return d;
  endfunction

  // later stages first so the youngest match wins
  function automatic fwd_t model_fwd(input logic [3:0] r);
    fwd_t f;
    f = FWD_NONE;
    if (m_w[2] && m_a[2] == r)
      f = FWD_RSTORE;
    if (m_w[1] && m_a[1] == r)
      f = FWD_MEM;
    if (m_w[0] && m_a[0] == r)
      f = FWD_ALU;
    return f;
  endfunction

  function automatic logic model_stall(input logic [3:0] rd, input logic [3:0] rn);
    if (m_w[0] && (m_a[0] == rd || m_a[0] == rn))
      return m_l[0];
    return m_w[1] && (m_a[1] == rd || m_a[1] == rn) && m_l[1];
  endfunction

  // check on the falling edge, then step the model to the next rising edge
  always @(negedge clk)
  begin
    exp = ref_decode(m_inst, m_valid && fetch_ready_i);
    e_rd_fwd = model_fwd(exp.rd);
    e_rn_fwd = model_fwd(exp.rn);
    e_stall = model_stall(exp.rd, exp.rn);
    got = {rd_addr_o, rn_addr_o, literal_o, op1_sel_o, op2_sel_o, alu_opcode_o,
           store_flags_o, is_branch_o, is_cond_branch_o, branch_rel_abs_o, branch_code_o,
           mem_read_o, mem_write_o, reg_write_o, wb_src_o, reg_write_addr_o, uut.bad_inst};
    if (!rst_i)
    begin
      assert (got == exp)
      else
      begin
        errors++;
        $display("mismatch at %0t ns: decode of %h got %h expected %h",
                 $time, m_inst, got, exp);
      end
      assert (branch_base_addr_o == m_addr)
      else
      begin
        errors++;
        $display("mismatch at %0t ns: branch base %h expected %h",
                 $time, branch_base_addr_o, m_addr);
      end
      assert (rd_fwd_o == e_rd_fwd && rn_fwd_o == e_rn_fwd)
      else
      begin
        errors++;
        $display("mismatch at %0t ns: forwards rd %0d rn %0d expected rd %0d rn %0d",
                 $time, rd_fwd_o, rn_fwd_o, e_rd_fwd, e_rn_fwd);
      end
      assert (decode_ready_o == (fetch_ready_i && !e_stall)
              && control_valid_o == (m_valid && !exp.bad && !e_stall))
      else
      begin
        errors++;
        $display("mismatch at %0t ns: ready %b valid %b with expected stall %b",
                 $time, decode_ready_o, control_valid_o, e_stall);
      end
    end

    if (rst_i)
    begin
      m_inst = '0;
      m_addr = '0;
      m_valid = 1'b0;
      for (int i = 0; i < 3; i++)
      begin
        m_w[i] = 1'b0;
        m_a[i] = '0;
        m_l[i] = 1'b0;
      end
    end
    else
    begin
      if (fetch_ready_i)
      begin
        m_w[2] = m_w[1];
        m_a[2] = m_a[1];
        m_w[1] = m_w[0];
        m_a[1] = m_a[0];
        m_l[1] = m_l[0];
        m_w[0] = exp.rwr && !e_stall;
        m_a[0] = exp.wa;
        m_l[0] = exp.mrd && !e_stall;
      end
      if (flush_i)
      begin
        m_inst = '0;
        m_addr = '0;
        m_valid = 1'b0;
      end
      else if (fetch_ready_i && !e_stall)
      begin
        m_valid = inst_valid_i;
        if (inst_valid_i)
        begin
          m_inst = instruction_i;
          m_addr = inst_addr_i;
        end
      end
    end
  end

  task automatic wait_ready();
    int spins;
    spins = 0;
    @(negedge clk);
    while (!decode_ready_o && spins < READY_LIMIT)
    begin
      @(negedge clk);
      spins++;
    end
    if (!decode_ready_o)
    begin
      errors++;
      $display("decode_ready_o stayed low for %0d cycles at %0t ns", READY_LIMIT, $time);
    end
  endtask

  // the word offered before is taken on this edge
  task automatic send_word(input logic [15:0] w);
    wait_ready();
    @(posedge clk);
    instruction_i <= w;
    inst_addr_i <= next_addr;
    inst_valid_i <= 1'b1;
    next_addr = next_addr + 2;
  endtask

  task automatic idle();
    wait_ready();
    @(posedge clk);
    inst_valid_i <= 1'b0;
  endtask

  task automatic flush_pulse();
    wait_ready();
    @(posedge clk);
    flush_i <= 1'b1;
    inst_valid_i <= 1'b0;
    @(posedge clk);
    flush_i <= 1'b0;
  endtask

  task automatic hold_fetch(input int cycles);
    wait_ready();
    @(posedge clk);
    inst_valid_i <= 1'b0;
    fetch_ready_i <= 1'b0;
    repeat (cycles) @(posedge clk);
    fetch_ready_i <= 1'b1;
  endtask

  initial
  begin
    rst_i = 1'b1;
    flush_i = 1'b0;
    instruction_i = '0;
    inst_valid_i = 1'b0;
    inst_addr_i = '0;
    fetch_ready_i = 1'b1;
    lfsr = 16'd60;
    next_addr = 32'h100;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    repeat (3) idle();

    for (int i = 0; i < NUM_RANDOM; i++)
      send_word(random_word());
    repeat (4) idle();

    // mov r5 then an alu read of r5 at distance 1 to 3
    for (int d = 1; d <= 3; d++)
    begin
      send_word(16'h4500);
      repeat (d - 1) send_word(16'h4700);
      send_word(16'h8015);
      repeat (4) idle();
    end

    // load r6 then use it at once
    send_word(16'h6620);
    send_word(16'h8016);
    repeat (5) idle();

    // pending write to r3 held under back-pressure
    send_word(16'h4300);
    send_word(16'h8013);
    hold_fetch(4);
    repeat (4) idle();

    send_word(16'h4900);
    send_word(16'h8019);
    flush_pulse();
    repeat (4) idle();

    $display("checks done: %0d testbench errors, %0d property failures",
             errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/decode_stage_props.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_props
  import decode_pkg::*;
(
  input wire                  clk,
  input wire                  rst_i,
  input wire                  flush_i,
  input wire                  fetch_ready_i,
  input wire                  stall_i,
  input wire [INST_WIDTH-1:0] inst_i,
  input wire                  valid_i,
  input wire                  decode_ready_i,
  input wire                  control_valid_i,
  input wire                  reg_write_i,
  input wire                  mem_read_i,
  input wire                  mem_write_i,
  input wire                  is_branch_i,
  input wire [1:0]            rd_fwd_i,
  input wire [1:0]            rn_fwd_i
);

  int fail_count = 0;

  // first cycle out of reset
  reset_quiet: assert property (@(posedge clk)
    rst_i |=> !control_valid_i && !reg_write_i && !mem_read_i && !mem_write_i
      && !is_branch_i && !stall_i && decode_ready_i == fetch_ready_i
      && rd_fwd_i == FWD_NONE && rn_fwd_i == FWD_NONE)
  else
  begin
    fail_count++;
    $error("control outputs not quiet after reset");
  end

  stall_holds_word: assert property (@(posedge clk) disable iff (rst_i)
    stall_i && !flush_i |=> $stable(inst_i))
  else
  begin
    fail_count++;
    $error("latched word changed during a stall");
  end

  flush_drops_word: assert property (@(posedge clk) disable iff (rst_i)
    flush_i |=> !control_valid_i && !valid_i)
  else
  begin
    fail_count++;
    $error("word still valid after flush");
  end

  // back-pressure zeroes the controls
  hold_is_quiet: assert property (@(posedge clk) disable iff (rst_i)
    !fetch_ready_i |-> !reg_write_i && !mem_read_i && !mem_write_i && !is_branch_i)
  else
  begin
    fail_count++;
    $error("control outputs active under back-pressure");
  end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
  import decode_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)(
  input  wire                       clk,
  input  wire                       rst_i,
  input  wire                       flush_i,
  input  wire  [INST_WIDTH-1:0]     instruction_i,
  input  wire                       inst_valid_i,
  input  wire  [DATA_WIDTH-1:0]     inst_addr_i,
  input  wire                       fetch_ready_i,
  output logic                      decode_ready_o,
  output logic                      control_valid_o,
  output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
  output logic [REG_ADDR_WIDTH-1:0] rn_addr_o,
  output logic [DATA_WIDTH-1:0]     literal_o,
  output op_src_t                   op1_sel_o,
  output op_src_t                   op2_sel_o,
  output alu_op_t                   alu_opcode_o,
  output logic [3:0]                store_flags_o,
  output logic                      is_branch_o,
  output logic                      is_cond_branch_o,
  output logic                      branch_rel_abs_o,
  output logic [2:0]                branch_code_o,
  output logic [DATA_WIDTH-1:0]     branch_base_addr_o,
  output logic                      mem_read_o,
  output logic                      mem_write_o,
  output logic                      reg_write_o,
  output wb_src_t                   wb_src_o,
  output logic [REG_ADDR_WIDTH-1:0] reg_write_addr_o,
  output fwd_t                      rd_fwd_o,
  output fwd_t                      rn_fwd_o
);

  logic [INST_WIDTH-1:0]     inst_r;
  logic [DATA_WIDTH-1:0]     addr_r;
  logic                      valid_r;
  logic                      stall;
  logic                      bad_inst;
  logic                      alu_wr;
  logic [REG_ADDR_WIDTH-1:0] alu_addr;
  logic                      alu_load;
  logic                      mem_wr;
  logic [REG_ADDR_WIDTH-1:0] mem_addr;
  logic                      mem_load;
  logic                      rs_wr;
  logic [REG_ADDR_WIDTH-1:0] rs_addr;

  assign decode_ready_o = fetch_ready_i && !stall;

  inst_latch #(.DATA_WIDTH(DATA_WIDTH)) u_latch (
    .clk, .rst_i, .flush_i, .fetch_ready_i,
    .stall_i(stall), .inst_valid_i, .instruction_i, .inst_addr_i,
    .inst_o(inst_r), .addr_o(addr_r), .valid_o(valid_r)
  );

  inst_decoder #(.DATA_WIDTH(DATA_WIDTH)) u_decoder (
    .valid_i(valid_r), .fetch_ready_i, .inst_i(inst_r), .addr_i(addr_r),
    .rd_addr_o, .rn_addr_o, .literal_o, .op1_sel_o, .op2_sel_o,
    .alu_opcode_o, .store_flags_o, .is_branch_o, .is_cond_branch_o,
    .branch_rel_abs_o, .branch_code_o, .branch_base_addr_o,
    .mem_read_o, .mem_write_o, .reg_write_o, .wb_src_o,
    .reg_write_addr_o, .bad_inst_o(bad_inst)
  );

  writeback_track u_track (
    .clk, .rst_i, .fetch_ready_i, .stall_i(stall),
    .reg_write_i(reg_write_o), .reg_write_addr_i(reg_write_addr_o),
    .mem_read_i(mem_read_o),
    .alu_write_o(alu_wr), .alu_addr_o(alu_addr), .alu_load_o(alu_load),
    .mem_write_o(mem_wr), .mem_addr_o(mem_addr), .mem_load_o(mem_load),
    .rstore_write_o(rs_wr), .rstore_addr_o(rs_addr)
  );

  hazard_resolve u_hazard (
    .alu_write_i(alu_wr), .alu_addr_i(alu_addr), .alu_load_i(alu_load),
    .mem_write_i(mem_wr), .mem_addr_i(mem_addr), .mem_load_i(mem_load),
    .rstore_write_i(rs_wr), .rstore_addr_i(rs_addr),
    .rd_addr_i(rd_addr_o), .rn_addr_i(rn_addr_o),
    .valid_i(valid_r), .bad_inst_i(bad_inst),
    .rd_fwd_o, .rn_fwd_o, .stall_o(stall), .control_valid_o
  );

endmodule

`default_nettype wire

// File: design/hazard_resolve.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_resolve
  import decode_pkg::*;
(
  input  wire                      alu_write_i,
  input  wire [REG_ADDR_WIDTH-1:0] alu_addr_i,
  input  wire                      alu_load_i,
  input  wire                      mem_write_i,
  input  wire [REG_ADDR_WIDTH-1:0] mem_addr_i,
  input  wire                      mem_load_i,
  input  wire                      rstore_write_i,
  input  wire [REG_ADDR_WIDTH-1:0] rstore_addr_i,
  input  wire [REG_ADDR_WIDTH-1:0] rd_addr_i,
  input  wire [REG_ADDR_WIDTH-1:0] rn_addr_i,
  input  wire                      valid_i,
  input  wire                      bad_inst_i,
  output fwd_t                     rd_fwd_o,
  output fwd_t                     rn_fwd_o,
  output logic                     stall_o,
  output logic                     control_valid_o
);

  logic alu_hit;
  logic mem_hit;

  // youngest producer wins
  function automatic fwd_t pick_fwd(input logic [REG_ADDR_WIDTH-1:0] addr);
    if (alu_write_i && alu_addr_i == addr)
      return FWD_ALU;
    else if (mem_write_i && mem_addr_i == addr)
      return FWD_MEM;
    else if (rstore_write_i && rstore_addr_i == addr)
      return FWD_RSTORE;
    return FWD_NONE;
  endfunction

  always_comb
  begin
    rd_fwd_o = pick_fwd(rd_addr_i);
    rn_fwd_o = pick_fwd(rn_addr_i);
  end

  assign alu_hit = alu_write_i && (alu_addr_i == rd_addr_i || alu_addr_i == rn_addr_i);
  assign mem_hit = mem_write_i && (mem_addr_i == rd_addr_i || mem_addr_i == rn_addr_i);

  // load data not ready until after mem
  assign stall_o = alu_hit ? alu_load_i : (mem_hit && mem_load_i);

  assign control_valid_o = valid_i && !bad_inst_i && !stall_o;

endmodule

`default_nettype wire

// File: design/writeback_track.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_track
  import decode_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst_i,
  input  wire                       fetch_ready_i,
  input  wire                       stall_i,
  input  wire                       reg_write_i,
  input  wire  [REG_ADDR_WIDTH-1:0] reg_write_addr_i,
  input  wire                       mem_read_i,
  output logic                      alu_write_o,
  output logic [REG_ADDR_WIDTH-1:0] alu_addr_o,
  output logic                      alu_load_o,
  output logic                      mem_write_o,
  output logic [REG_ADDR_WIDTH-1:0] mem_addr_o,
  output logic                      mem_load_o,
  output logic                      rstore_write_o,
  output logic [REG_ADDR_WIDTH-1:0] rstore_addr_o
);

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      alu_write_o    <= 1'b0;
      alu_addr_o     <= '0;
      alu_load_o     <= 1'b0;
      mem_write_o    <= 1'b0;
      mem_addr_o     <= '0;
      mem_load_o     <= 1'b0;
      rstore_write_o <= 1'b0;
      rstore_addr_o  <= '0;
    end
    else if (fetch_ready_i)
    begin
      // stalled word inserts a bubble
      alu_write_o    <= reg_write_i && !stall_i;
      alu_load_o     <= mem_read_i && !stall_i;
      alu_addr_o     <= reg_write_addr_i;
      mem_write_o    <= alu_write_o;
      mem_load_o     <= alu_load_o;
      mem_addr_o     <= alu_addr_o;
      rstore_write_o <= mem_write_o;
      rstore_addr_o  <= mem_addr_o;
    end
  end

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder
  import decode_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)(
  input  wire                       valid_i,
  input  wire                       fetch_ready_i,
  input  wire  [INST_WIDTH-1:0]     inst_i,
  input  wire  [DATA_WIDTH-1:0]     addr_i,
  output logic [REG_ADDR_WIDTH-1:0] rd_addr_o,
  output logic [REG_ADDR_WIDTH-1:0] rn_addr_o,
  output logic [DATA_WIDTH-1:0]     literal_o,
  output op_src_t                   op1_sel_o,
  output op_src_t                   op2_sel_o,
  output alu_op_t                   alu_opcode_o,
  output logic [3:0]                store_flags_o,
  output logic                      is_branch_o,
  output logic                      is_cond_branch_o,
  output logic                      branch_rel_abs_o,
  output logic [2:0]                branch_code_o,
  output logic [DATA_WIDTH-1:0]     branch_base_addr_o,
  output logic                      mem_read_o,
  output logic                      mem_write_o,
  output logic                      reg_write_o,
  output wb_src_t                   wb_src_o,
  output logic [REG_ADDR_WIDTH-1:0] reg_write_addr_o,
  output logic                      bad_inst_o
);

  assign branch_base_addr_o = addr_i;

  always_comb
  begin
    rd_addr_o        = '0;
    rn_addr_o        = '0;
    literal_o        = '0;
    op1_sel_o        = SRC_RD;
    op2_sel_o        = SRC_RD;
    alu_opcode_o     = OP_AND;
    store_flags_o    = 4'h0;
    is_branch_o      = 1'b0;
    is_cond_branch_o = 1'b0;
    branch_rel_abs_o = 1'b0;
    branch_code_o    = 3'd0;
    mem_read_o       = 1'b0;
    mem_write_o      = 1'b0;
    reg_write_o      = 1'b0;
    wb_src_o         = WB_ALU;
    reg_write_addr_o = '0;
    bad_inst_o       = 1'b0;

    if (valid_i && fetch_ready_i)
    begin
      casez (inst_i[ID_HI:ID_LO])
        CLS_NOP, CLS_RES:
          bad_inst_o = 1'b1;
        CLS_EXT:
        begin
          rd_addr_o        = inst_i[EXT_RD_HI:EXT_RD_LO];
          op2_sel_o        = SRC_RN;
          alu_opcode_o     = inst_i[EXT_ZS] ? OP_ZEX : OP_SEX;
          reg_write_o      = 1'b1;
          reg_write_addr_o = inst_i[EXT_RD_HI:EXT_RD_LO];
        end
        CLS_BCOND:
        begin
          rn_addr_o        = inst_i[BC_RN_HI:BC_RN_LO];
          literal_o        = {{(DATA_WIDTH-8){inst_i[BC_LIT_HI]}}, inst_i[BC_LIT_HI:BC_LIT_LO]};
          op2_sel_o        = inst_i[BC_SRC] ? SRC_RN : SRC_LIT;
          alu_opcode_o     = OP_MOV;
          is_branch_o      = 1'b1;
          is_cond_branch_o = 1'b1;
          branch_code_o    = inst_i[BC_CODE_HI:BC_CODE_LO];
          branch_rel_abs_o = inst_i[BC_LINK];
          // link and relative share bit 11
          reg_write_o      = inst_i[BC_LINK];
          wb_src_o         = WB_BRANCH;
          reg_write_addr_o = REG_LINK;
        end
        CLS_MOV:
        begin
          rn_addr_o        = inst_i[MOV_RN_HI:MOV_RN_LO];
          literal_o        = DATA_WIDTH'(inst_i[MOV_LIT_HI:MOV_LIT_LO]);
          op1_sel_o        = SRC_LIT;
          op2_sel_o        = inst_i[MOV_SRC] ? SRC_LIT : SRC_RN;
          alu_opcode_o     = OP_MOV;
          reg_write_o      = 1'b1;
          reg_write_addr_o = inst_i[MOV_RD_HI:MOV_RD_LO];
        end
        CLS_LDSTR:
        begin
          // address is rn plus the short offset
          rd_addr_o        = inst_i[LS_RD_HI:LS_RD_LO];
          rn_addr_o        = inst_i[LS_RN_HI:LS_RN_LO];
          literal_o        = DATA_WIDTH'(inst_i[LS_LIT_HI:LS_LIT_LO]);
          op1_sel_o        = SRC_RN;
          op2_sel_o        = SRC_LIT;
          alu_opcode_o     = OP_ADD;
          mem_read_o       = !inst_i[LS_TYPE];
          mem_write_o      = inst_i[LS_TYPE];
          reg_write_o      = !inst_i[LS_TYPE];
          wb_src_o         = WB_MEM;
          reg_write_addr_o = inst_i[LS_RD_HI:LS_RD_LO];
        end
        CLS_ALU:
        begin
          rd_addr_o        = inst_i[ALU_RD_HI:ALU_RD_LO];
          rn_addr_o        = inst_i[ALU_RN_HI:ALU_RN_LO];
          literal_o        = DATA_WIDTH'(inst_i[ALU_LIT_HI:ALU_LIT_LO]);
          op2_sel_o        = inst_i[ALU_SRC] ? SRC_RN : SRC_LIT;
          alu_opcode_o     = alu_op_t'(inst_i[ALU_CODE_HI:ALU_CODE_LO]);
          store_flags_o    = 4'hf;
          reg_write_o      = 1'b1;
          reg_write_addr_o = inst_i[ALU_RD_HI:ALU_RD_LO];
        end
        CLS_SHIFT:
        begin
          rd_addr_o        = inst_i[SH_RD_HI:SH_RD_LO];
          rn_addr_o        = inst_i[SH_RN_HI:SH_RN_LO];
          literal_o        = DATA_WIDTH'(inst_i[SH_LIT_HI:SH_LIT_LO]);
          op2_sel_o        = inst_i[SH_SRC] ? SRC_RN : SRC_LIT;
          alu_opcode_o     = alu_op_t'(OP_LSR + {2'b00, inst_i[SH_CODE_HI:SH_CODE_LO]});
          store_flags_o    = 4'hf;
          reg_write_o      = 1'b1;
          reg_write_addr_o = inst_i[SH_RD_HI:SH_RD_LO];
        end
        CLS_PUPO:
        begin
          // stack pointer moves by one word
          rd_addr_o        = REG_STACK;
          rn_addr_o        = inst_i[PP_RN_HI:PP_RN_LO];
          literal_o        = DATA_WIDTH'(PUSH_POP_STEP);
          op2_sel_o        = SRC_LIT;
          alu_opcode_o     = inst_i[PP_TYPE] ? OP_ADD : OP_SUB;
          mem_read_o       = inst_i[PP_TYPE];
          mem_write_o      = !inst_i[PP_TYPE];
          reg_write_o      = inst_i[PP_TYPE];
          wb_src_o         = WB_MEM;
          reg_write_addr_o = inst_i[PP_RN_HI:PP_RN_LO];
        end
        CLS_BUNC:
        begin
          rn_addr_o        = inst_i[BU_RN_HI:BU_RN_LO];
          literal_o        = {{(DATA_WIDTH-10){inst_i[BU_LIT_HI]}}, inst_i[BU_LIT_HI:BU_LIT_LO]};
          op1_sel_o        = SRC_LIT;
          op2_sel_o        = inst_i[BU_SRC] ? SRC_RN : SRC_LIT;
          is_branch_o      = 1'b1;
          branch_rel_abs_o = inst_i[BU_SRC];
          reg_write_o      = inst_i[BU_LINK];
          wb_src_o         = WB_BRANCH;
          reg_write_addr_o = REG_LINK;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/inst_latch.sv
`timescale 1ns/100ps
`default_nettype none

module inst_latch
  import decode_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)(
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   flush_i,
  input  wire                   fetch_ready_i,
  input  wire                   stall_i,
  input  wire                   inst_valid_i,
  input  wire  [INST_WIDTH-1:0] instruction_i,
  input  wire  [DATA_WIDTH-1:0] inst_addr_i,
  output logic [INST_WIDTH-1:0] inst_o,
  output logic [DATA_WIDTH-1:0] addr_o,
  output logic                  valid_o
);

  always_ff @(posedge clk)
  begin
    if (rst_i || flush_i)
    begin
      inst_o  <= '0;
      addr_o  <= '0;
      valid_o <= 1'b0;
    end
    else if (fetch_ready_i && !stall_i)
    begin
      // word consumed this cycle
      valid_o <= 1'b0;
      if (inst_valid_i)
      begin
        inst_o  <= instruction_i;
        addr_o  <= inst_addr_i;
        valid_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int INST_WIDTH     = 16;
  localparam int REG_ADDR_WIDTH = 4;

  localparam logic [REG_ADDR_WIDTH-1:0] REG_STACK = 4'd13;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_LINK  = 4'd14;
  localparam int PUSH_POP_STEP = 4;

  // class id in the top four bits
  localparam int ID_HI = 15;
  localparam int ID_LO = 12;

  localparam logic [3:0] CLS_NOP   = 4'b0000;
  localparam logic [3:0] CLS_EXT   = 4'b0001;
  localparam logic [3:0] CLS_BCOND = 4'b001?;
  localparam logic [3:0] CLS_MOV   = 4'b010?;
  localparam logic [3:0] CLS_LDSTR = 4'b011?;
  localparam logic [3:0] CLS_ALU   = 4'b100?;
  localparam logic [3:0] CLS_SHIFT = 4'b101?;
  localparam logic [3:0] CLS_RES   = 4'b110?;
  localparam logic [3:0] CLS_PUPO  = 4'b1110;
  localparam logic [3:0] CLS_BUNC  = 4'b1111;

  localparam int EXT_RD_HI = 7;
  localparam int EXT_RD_LO = 4;
  localparam int EXT_ZS    = 11;

  localparam int BC_RN_HI   = 3;
  localparam int BC_RN_LO   = 0;
  localparam int BC_LIT_HI  = 7;
  localparam int BC_LIT_LO  = 0;
  localparam int BC_CODE_HI = 10;
  localparam int BC_CODE_LO = 8;
  localparam int BC_LINK    = 11;
  localparam int BC_SRC     = 12;

  localparam int MOV_RD_HI  = 11;
  localparam int MOV_RD_LO  = 8;
  localparam int MOV_RN_HI  = 3;
  localparam int MOV_RN_LO  = 0;
  localparam int MOV_LIT_HI = 7;
  localparam int MOV_LIT_LO = 0;
  localparam int MOV_SRC    = 12;

  localparam int LS_RD_HI  = 11;
  localparam int LS_RD_LO  = 8;
  localparam int LS_RN_HI  = 7;
  localparam int LS_RN_LO  = 4;
  localparam int LS_LIT_HI = 3;
  localparam int LS_LIT_LO = 0;
  localparam int LS_TYPE   = 12;

  localparam int ALU_RD_HI   = 7;
  localparam int ALU_RD_LO   = 4;
  localparam int ALU_RN_HI   = 3;
  localparam int ALU_RN_LO   = 0;
  localparam int ALU_LIT_HI  = 3;
  localparam int ALU_LIT_LO  = 0;
  localparam int ALU_CODE_HI = 11;
  localparam int ALU_CODE_LO = 8;
  localparam int ALU_SRC     = 12;

  localparam int SH_RD_HI   = 11;
  localparam int SH_RD_LO   = 8;
  localparam int SH_RN_HI   = 3;
  localparam int SH_RN_LO   = 0;
  localparam int SH_LIT_HI  = 4;
  localparam int SH_LIT_LO  = 0;
  localparam int SH_CODE_HI = 7;
  localparam int SH_CODE_LO = 6;
  localparam int SH_SRC     = 12;

  localparam int PP_RN_HI = 3;
  localparam int PP_RN_LO = 0;
  localparam int PP_TYPE  = 11;

  localparam int BU_RN_HI  = 3;
  localparam int BU_RN_LO  = 0;
  localparam int BU_LIT_HI = 9;
  localparam int BU_LIT_LO = 0;
  localparam int BU_LINK   = 10;
  localparam int BU_SRC    = 11;

  typedef enum logic [3:0] {
    OP_AND = 4'd0, OP_OR, OP_XOR, OP_NOT,
    OP_NEG, OP_MUL, OP_DIV, OP_REM,
    OP_ADD = 4'd8, OP_SUB, OP_SEX, OP_ZEX,
    OP_LSR = 4'd12, OP_LSL, OP_ASR, OP_MOV = 4'd15
  } alu_op_t;

  typedef enum logic [1:0] {SRC_RD = 2'd0, SRC_RN = 2'd1, SRC_LIT = 2'd2} op_src_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0, FWD_ALU = 2'd1, FWD_MEM = 2'd2, FWD_RSTORE = 2'd3
  } fwd_t;

  typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_BRANCH = 2'd2} wb_src_t;

endpackage

`default_nettype wire
